// File: test/decode_tests.txt
# name instr valid wbEn wbAddr wbData wbClr stall brStall jump jal issue unitEn minorOp
# wbSrc destAddr destWrite aSel aVal bSel bVal (sel 0 literal, 1 register, 2 register low byte)
alu0Rr    0329 1 0 0 0000 0  0 0 0 0 1  01 2 2 3 1  1 0003 1 0009
alu1Rr    1456 1 0 0 0000 0  0 0 0 0 1  02 5 3 4 1  1 0004 1 0006
cplxR5    2578 1 0 0 0000 0  0 0 0 0 1  04 7 0 5 0  1 0005 1 0008
stallR5   0305 1 0 0 0000 0  1 0 0 0 0  00 0 0 0 0  0 0000 0 0000
stallR5b  0305 1 0 0 0000 0  1 0 0 0 0  00 0 0 0 0  0 0000 0 0000
wbR5      0305 1 1 5 beef 1  0 0 0 0 1  01 0 2 3 1  1 0003 1 0005
memR10    3a0b 1 0 0 0000 0  0 0 0 0 1  08 0 0 a 0  1 000a 1 000b
wawR10    1a12 1 0 0 0000 0  1 0 0 0 0  00 0 0 0 0  0 0000 0 0000
wbR10     1a12 1 1 a 1234 1  0 0 0 0 1  02 1 3 a 1  1 000a 1 0002
immLow    c3ab 1 0 0 0000 0  0 0 0 0 1  00 7 2 3 1  0 0000 0 00ab
immZext   daf5 1 0 0 0000 0  0 0 0 0 1  00 7 2 9 1  0 0000 0 02f5
immOnes   f155 1 0 0 0000 0  0 0 0 0 1  00 7 2 1 1  0 0000 0 fd55
immUpper  e6c8 1 0 0 0000 0  0 0 0 0 1  00 7 2 6 1  2 0006 0 c800
brNonZero a204 1 0 0 0000 0  0 1 0 0 1  10 0 0 2 0  1 0002 1 0004
brZero    a003 1 0 0 0000 0  0 0 1 0 0  00 0 0 0 0  0 0000 0 0000
jalReg    8712 1 0 0 0000 0  0 1 0 1 1  10 1 1 7 1  1 0007 1 0002
jalImm    9d23 1 0 0 0000 0  0 1 0 1 1  10 7 1 c 1  1 000c 0 0123
invalid   0329 0 0 0 0000 0  0 0 0 0 0  00 0 0 0 0  0 0000 0 0000
badOpcode 4123 1 0 0 0000 0  0 0 0 0 0  00 0 0 0 0  0 0000 0 0000

// File: sources.f
+incdir+include
logic/CorePkg.sv
logic/DecodeBus.sv
logic/InstructionDecoder.sv
logic/RegisterFile.sv
logic/Scoreboard.sv
logic/IssueStage.sv
logic/DecodeIssueUnit.sv
test/DecodeIssueTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
TOP       = DecodeIssueTb
RTL_TOP   = DecodeIssueUnit
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/DecodeIssueTb.sv
`timescale 1ns/1ps
`default_nettype none

module DecodeIssueTb import CorePkg::*; ();

    localparam int issueTimeout = 20;

    logic         clk;
    logic         rst;
    logic [15:0]  Instruction;
    logic         InstructionValid;
    logic         WbEn;
    regAddr       WbAddr;
    dataWord      WbData;
    logic         WbClearDirty;
    logic         Stall;
    logic         BranchStall;
    logic         JumpEn;
    logic         JumpAndLinkEn;
    logic         IssueValid;
    unitEnable    IssueUnitEn;
    minorOp       IssueMinorOp;
    wbSource      IssueWbSrc;
    regAddr       IssueDestAddr;
    logic         IssueDestWrite;
    dataWord      IssueOperandA;
    dataWord      IssueOperandB;

    // Register contents as the testbench expects them
    dataWord      regMirror [16];
    logic [31:0]  lcgState;
    int           errorCount;
    int           timeoutCount;
    int           stepCount;
    string        stepName;

    // Fields of the current test line
    logic [127:0] nameBits;
    logic [15:0]  lineInstr;
    logic         lineValid;
    logic         lineWbEn;
    regAddr       lineWbAddr;
    dataWord      lineWbData;
    logic         lineWbClear;
    logic         expStall;
    logic         expBranchStall;
    logic         expJump;
    logic         expJal;
    logic         expIssue;
    unitEnable    expUnitEn;
    minorOp       expMinorOp;
    wbSource      expWbSrc;
    regAddr       expDestAddr;
    logic         expDestWrite;
    logic [1:0]   selA;
    logic [15:0]  valA;
    logic [1:0]   selB;
    logic [15:0]  valB;

    DecodeIssueUnit dut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Operand source code from the test file
    function automatic dataWord expectedOperand(input logic [1:0] sel, input logic [15:0] val);
        case (sel)
            2'd1: return regMirror[val[3:0]];
            // Upper immediate only passes the low byte of register A
            2'd2: return {8'h00, regMirror[val[3:0]][7:0]};
            default: return val;
        endcase
    endfunction

    task automatic compareField(input string fieldName, input logic [15:0] expected,
                                input logic [15:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s %s expected %h actual %h", stepName, fieldName,
                     expected, actual);
            errorCount++;
        end
    endtask

    task automatic driveInputs(input logic [15:0] instr, input logic valid,
                               input logic wbEnable, input regAddr wbAddress,
                               input dataWord wbValue, input logic wbClear);
        Instruction      = instr;
        InstructionValid = valid;
        WbEn             = wbEnable;
        WbAddr           = wbAddress;
        WbData           = wbValue;
        WbClearDirty     = wbClear;
        // Write lands at the next edge, register 0 stays zero
        if (wbEnable && wbAddress != 4'd0) begin
            regMirror[wbAddress] = wbValue;
        end
    endtask

    // Returns the cycles until the issue pulse, 0 on timeout
    task automatic waitForIssue(output int cycles);
        int waited;
        @(negedge clk);
        waited = 1;
        while (!IssueValid && waited < issueTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (IssueValid) begin
            cycles = waited;
        end else begin
            cycles = 0;
            $display("Timeout: %s did not issue within %0d cycles", stepName, issueTimeout);
            timeoutCount++;
        end
    endtask

    // Every register read on both ports by an ALU 0 instruction
    task automatic readBackRegisters(input string label);
        logic [3:0] sel;
        int         cycles;
        for (int i = 0; i < 16; i++) begin
            sel = 4'(i);
            stepName = $sformatf("%s%0d", label, i);
            driveInputs({4'h0, sel, 4'h0, sel}, 1'b1, 1'b0, 4'd0, 16'h0000, 1'b0);
            waitForIssue(cycles);
            if (cycles != 0) begin
                compareField("operandA", regMirror[sel], IssueOperandA);
                compareField("operandB", regMirror[sel], IssueOperandB);
            end
        end
        driveInputs(16'h0000, 1'b0, 1'b0, 4'd0, 16'h0000, 1'b0);
    endtask

    task automatic preloadRegisters();
        for (int i = 1; i < 16; i++) begin
            lcgState = lcgNext(lcgState);
            driveInputs(16'h0000, 1'b0, 1'b1, 4'(i), lcgState[31:16], 1'b0);
            @(negedge clk);
        end
        driveInputs(16'h0000, 1'b0, 1'b0, 4'd0, 16'h0000, 1'b0);
    endtask

    task automatic runStep();
        int cycles;
        stepCount++;
        driveInputs(lineInstr, lineValid, lineWbEn, lineWbAddr, lineWbData, lineWbClear);
        // Decode levels settle well before the rising edge
        #10;
        compareField("stall", 16'(expStall), 16'(Stall));
        compareField("branchStall", 16'(expBranchStall), 16'(BranchStall));
        compareField("jumpEn", 16'(expJump), 16'(JumpEn));
        compareField("jumpAndLinkEn", 16'(expJal), 16'(JumpAndLinkEn));
        if (expIssue) begin
            waitForIssue(cycles);
            if (cycles > 1) begin
                $display("Error: %s issued after %0d cycles instead of one", stepName, cycles);
                errorCount++;
            end
            if (cycles != 0) begin
                compareField("unitEn", 16'(expUnitEn), 16'(IssueUnitEn));
                compareField("minorOp", 16'(expMinorOp), 16'(IssueMinorOp));
                compareField("wbSrc", 16'(expWbSrc), 16'(IssueWbSrc));
                compareField("destAddr", 16'(expDestAddr), 16'(IssueDestAddr));
                compareField("destWrite", 16'(expDestWrite), 16'(IssueDestWrite));
                compareField("operandA", expectedOperand(selA, valA), IssueOperandA);
                compareField("operandB", expectedOperand(selB, valB), IssueOperandB);
            end
        end else begin
            @(negedge clk);
            compareField("issueValid", 16'd0, 16'(IssueValid));
        end
    endtask

    initial begin
        int    fd;
        int    fields;
        int    lineCount;
        string lineText;
        clk          = 1'b0;
        rst          = 1'b1;
        errorCount   = 0;
        timeoutCount = 0;
        stepCount    = 0;
        lineCount    = 0;
        lcgState     = 32'h783e;
        // A valid ALU 0 instruction during reset must not issue
        driveInputs(16'h0329, 1'b1, 1'b0, 4'd0, 16'h0000, 1'b0);
        for (int i = 0; i < 16; i++) begin
            regMirror[i] = '0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        stepName = "reset";
        compareField("issueValid", 16'd0, 16'(IssueValid));
        readBackRegisters("zero");
        preloadRegisters();
        readBackRegisters("preload");
        fd = $fopen("test/decode_tests.txt", "r");
        if (fd == 0) begin
            $display("Error: could not open test/decode_tests.txt");
            errorCount++;
        end else begin
            while (!$feof(fd) && lineCount < 1000) begin
                lineCount++;
                if ($fgets(lineText, fd) != 0 && lineText.len() > 1 && lineText[0] != "#") begin
                    fields = $sscanf(lineText,
                        "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        nameBits, lineInstr, lineValid, lineWbEn, lineWbAddr, lineWbData,
                        lineWbClear, expStall, expBranchStall, expJump, expJal, expIssue,
                        expUnitEn, expMinorOp, expWbSrc, expDestAddr, expDestWrite,
                        selA, valA, selB, valB);
                    if (fields != 21) begin
                        $display("Error: test file line %0d is malformed", lineCount);
                        errorCount++;
                    end else begin
                        stepName = $sformatf("%0s", nameBits);
                        runStep();
                    end
                end
            end
            $fclose(fd);
        end
        if (stepCount == 0) begin
            $display("Error: no test steps were read from the test file");
            errorCount++;
        end
        driveInputs(16'h0000, 1'b0, 1'b0, 4'd0, 16'h0000, 1'b0);
        @(negedge clk);
        $display("Summary: %0d steps, %0d errors, %0d timeouts", stepCount, errorCount,
                 timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/DecodeIssueUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module DecodeIssueUnit import CorePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`INSTR_WIDTH-1:0] Instruction,
    input  logic                    InstructionValid,
    input  logic                    WbEn,
    input  regAddr                  WbAddr,
    input  dataWord                 WbData,
    input  logic                    WbClearDirty,
    output logic                    Stall,
    output logic                    BranchStall,
    output logic                    JumpEn,
    output logic                    JumpAndLinkEn,
    output logic                    IssueValid,
    output unitEnable               IssueUnitEn,
    output minorOp                  IssueMinorOp,
    output wbSource                 IssueWbSrc,
    output regAddr                  IssueDestAddr,
    output logic                    IssueDestWrite,
    output dataWord                 IssueOperandA,
    output dataWord                 IssueOperandB
);

    logic    hazard;
    logic    issuePulse;
    dataWord readDataA;
    dataWord readDataB;

    DecodeBus decodeBus ();

    InstructionDecoder decoder (
        .instruction      (Instruction),
        .instructionValid (InstructionValid),
        .bus              (decodeBus.decoder),
        .branchStall      (BranchStall),
        .jumpEn           (JumpEn),
        .jumpAndLinkEn    (JumpAndLinkEn)
    );

    RegisterFile registerFile (
        .clk       (clk),
        .rst       (rst),
        .readAddrA (decodeBus.regAAddr),
        .readAddrB (decodeBus.regBAddr),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .writeEn   (WbEn),
        .writeAddr (WbAddr),
        .writeData (WbData)
    );

    Scoreboard scoreboard (
        .clk       (clk),
        .rst       (rst),
        .bus       (decodeBus.scoreboard),
        .issue     (issuePulse),
        .clearEn   (WbClearDirty),
        .clearAddr (WbAddr),
        .hazard    (hazard)
    );

    IssueStage issueStage (
        .clk              (clk),
        .rst              (rst),
        .instructionValid (InstructionValid),
        .hazard           (hazard),
        .bus              (decodeBus.issue),
        .readDataA        (readDataA),
        .readDataB        (readDataB),
        .issue            (issuePulse),
        .issueValid       (IssueValid),
        .issueUnitEn      (IssueUnitEn),
        .issueMinorOp     (IssueMinorOp),
        .issueWbSrc       (IssueWbSrc),
        .issueDestAddr    (IssueDestAddr),
        .issueDestWrite   (IssueDestWrite),
        .issueOperandA    (IssueOperandA),
        .issueOperandB    (IssueOperandB)
    );

    // Fetch holds its instruction while a hazard is pending
    assign Stall = hazard;

endmodule

`default_nettype wire

// File: logic/IssueStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module IssueStage import CorePkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      instructionValid,
    input  logic      hazard,
    DecodeBus.issue   bus,
    input  dataWord   readDataA,
    input  dataWord   readDataB,
    output logic      issue,
    output logic      issueValid,
    output unitEnable issueUnitEn,
    output minorOp    issueMinorOp,
    output wbSource   issueWbSrc,
    output regAddr    issueDestAddr,
    output logic      issueDestWrite,
    output dataWord   issueOperandA,
    output dataWord   issueOperandB
);

    logic    hasWork;
    dataWord operandA;
    dataWord operandB;

    // An all-zero operation vector has neither a unit nor a destination
    assign hasWork = (bus.unitEn != '0) || bus.regAWriteEn;
    assign issue   = instructionValid && hasWork && !hazard;

    // Upper immediate keeps the low byte of register A, and ALU 0 merges it
    // with the shifted immediate on operand B
    always_comb begin
        if (!bus.regAReadEn) begin
            operandA = '0;
        end else if (bus.upperImmEn) begin
            operandA = {{(`DATA_WIDTH-8){1'b0}}, readDataA[7:0]};
        end else begin
            operandA = readDataA;
        end
    end

    always_comb begin
        if (bus.immEn) begin
            operandB = bus.immediate;
        end else if (bus.regBReadEn) begin
            operandB = readDataB;
        end else begin
            operandB = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= issue;
        end
    end

    // Payload only moves on an issue, consumers qualify it with issueValid
    always_ff @(posedge clk) begin
        if (issue) begin
            issueUnitEn    <= bus.unitEn;
            issueMinorOp   <= bus.minorOp;
            issueWbSrc     <= bus.wbSrc;
            issueDestAddr  <= bus.regAAddr;
            issueDestWrite <= bus.regAWriteEn;
            issueOperandA  <= operandA;
            issueOperandB  <= operandB;
        end
    end

endmodule

`default_nettype wire

// File: logic/Scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module Scoreboard import CorePkg::*; (
    input  logic         clk,
    input  logic         rst,
    DecodeBus.scoreboard bus,
    input  logic         issue,
    input  logic         clearEn,
    input  regAddr       clearAddr,
    output logic         hazard
);

    logic [`REG_COUNT-1:0] dirtyBits;
    logic [`REG_COUNT-1:0] clearMask;
    logic [`REG_COUNT-1:0] setMask;
    logic [`REG_COUNT-1:0] liveDirty;
    logic                  regAHazard;
    logic                  regBHazard;

    always_comb begin
        clearMask = '0;
        if (clearEn) begin
            clearMask[clearAddr] = 1'b1;
        end
    end

    // Register 0 never becomes dirty
    always_comb begin
        setMask = '0;
        if (issue && bus.dirtyTrigger && bus.regAAddr != '0) begin
            setMask[bus.regAAddr] = 1'b1;
        end
    end

    // A writeback this cycle already releases its register
    assign liveDirty = dirtyBits & ~clearMask;

    // Register A counts when read or when it is the destination
    assign regAHazard = (bus.regAReadEn || bus.regAWriteEn) && liveDirty[bus.regAAddr];
    assign regBHazard = bus.regBReadEn && liveDirty[bus.regBAddr];
    assign hazard     = regAHazard || regBHazard;

    // New issue wins over a clear of the same register
    always_ff @(posedge clk) begin
        if (rst) begin
            dirtyBits <= '0;
        end else begin
            dirtyBits <= liveDirty | setMask;
        end
    end

endmodule

`default_nettype wire

// File: logic/RegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module RegisterFile import CorePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  regAddr  readAddrA,
    input  regAddr  readAddrB,
    output dataWord readDataA,
    output dataWord readDataB,
    input  logic    writeEn,
    input  regAddr  writeAddr,
    input  dataWord writeData
);

    dataWord regs [`REG_COUNT];
    logic    writeHit;

    // Register 0 is hard zero and never takes a write
    assign writeHit = writeEn && (writeAddr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeHit) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Bypass so a reader sees the writeback landing this cycle
    assign readDataA = (readAddrA == '0) ? '0 :
                       (writeHit && writeAddr == readAddrA) ? writeData : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 :
                       (writeHit && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

`default_nettype wire

// File: logic/InstructionDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module InstructionDecoder import CorePkg::*; (
    input  logic [`INSTR_WIDTH-1:0] instruction,
    input  logic                    instructionValid,
    DecodeBus.decoder               bus,
    output logic                    branchStall,
    output logic                    jumpEn,
    output logic                    jumpAndLinkEn
);

    logic [15:0] operationBitVector;
    logic [4:0]  instructionCondition;
    logic        upperAAddrEn;
    logic        regANonZero;
    logic        jumpAndLink;
    regAddr      regA;
    dataWord     immediateMux;

    // J-type immediate and immediate opcodes carry register A in the upper form
    assign upperAAddrEn = instruction[15] && instruction[12];
    assign regA = upperAAddrEn ? {instruction[11:10], 1'b0, instruction[14]}
                               : instruction[`REG_A_MSB:`REG_A_LSB];
    assign regANonZero = (regA != '0);

    // Operation bit vector layout
    // 0 dirty trigger, 5:1 unit enable, 7:6 writeback source,
    // 8 immediate, 9 upper immediate, 10 reg A read, 11 reg A write,
    // 12 reg B read, 13 branch stall, 14 jump and link, 15 PC enable
    assign instructionCondition = {instructionValid, instruction[`OPCODE_MSB:`OPCODE_LSB]};

    always_comb begin
        casez (instructionCondition)
            // ALU 0
            5'b1_0000: operationBitVector = 16'b00_0_1_1_1_0_0_10_00001_0;
            // ALU 1
            5'b1_0001: operationBitVector = 16'b00_0_1_1_1_0_0_11_00010_0;
            // Complex ALU, long latency so it marks its destination dirty
            5'b1_0010: operationBitVector = 16'b00_0_1_0_1_0_0_00_00100_1;
            // Memory
            5'b1_0011: operationBitVector = 16'b00_0_1_0_1_0_0_00_01000_1;
            // Jump and link, register target
            5'b1_1000: operationBitVector = {3'b111, 13'b1_1_1_0_0_01_10000_0};
            // Jump and link, immediate target
            5'b1_1001: operationBitVector = {3'b111, 13'b0_1_1_0_1_01_10000_0};
            // Branch, register target
            5'b1_1010: operationBitVector = {2'b10, regANonZero, 7'b1_0_1_0_0_00,
                                             regANonZero, 5'b0000_0};
            // Branch, immediate target
            5'b1_1011: operationBitVector = {2'b10, regANonZero, 7'b0_0_1_0_1_00,
                                             regANonZero, 5'b0000_0};
            // Upper immediate
            5'b1_1110: operationBitVector = 16'b00_0_0_1_1_1_1_10_00000_0;
            // Remaining immediate forms
            5'b1_11??: operationBitVector = 16'b00_0_0_1_0_0_1_10_00000_0;
            default:   operationBitVector = '0;
        endcase
    end

    // Immediate forms selected by the low opcode bits
    always_comb begin
        case (instruction[`IMM_SEL_MSB:`IMM_SEL_LSB])
            2'b01:   immediateMux = {{(`DATA_WIDTH-10){1'b0}}, instruction[9:0]};
            2'b10:   immediateMux = {instruction[7:0], {(`DATA_WIDTH-8){1'b0}}};
            2'b11:   immediateMux = {{(`DATA_WIDTH-10){~operationBitVector[15]}},
                                     instruction[9:0]};
            default: immediateMux = {{(`DATA_WIDTH-8){1'b0}}, instruction[7:0]};
        endcase
    end

    assign bus.dirtyTrigger = operationBitVector[0];
    assign bus.unitEn       = operationBitVector[5:1];
    assign bus.wbSrc        = operationBitVector[7:6];
    assign bus.immEn        = operationBitVector[8];
    assign bus.upperImmEn   = operationBitVector[9];
    assign bus.regAReadEn   = operationBitVector[10];
    assign bus.regAWriteEn  = operationBitVector[11];
    assign bus.regBReadEn   = operationBitVector[12];
    assign bus.immediate    = immediateMux;
    assign bus.regAAddr     = regA;
    assign bus.regBAddr     = instruction[`REG_B_MSB:`REG_B_LSB];

    // Immediates run on ALU 0 with a fixed minor opcode
    assign bus.minorOp = operationBitVector[8] ? `IMM_MINOR_OP
                                               : instruction[`MINOR_OP_MSB:`MINOR_OP_LSB];

    assign branchStall   = operationBitVector[13];
    assign jumpAndLink   = operationBitVector[14];
    assign jumpAndLinkEn = jumpAndLink;
    // Branch on register 0 is always taken, so it becomes a plain jump
    assign jumpEn = !branchStall && !jumpAndLink && operationBitVector[15];

endmodule

`default_nettype wire

// File: logic/DecodeBus.sv
`timescale 1ns/1ps
`default_nettype none

interface DecodeBus import CorePkg::*; ();

    logic            dirtyTrigger;
    unitEnable       unitEn;
    wbSource         wbSrc;
    CorePkg::minorOp minorOp;
    logic            immEn;
    logic            upperImmEn;
    dataWord         immediate;
    logic            regAReadEn;
    logic            regAWriteEn;
    regAddr          regAAddr;
    logic            regBReadEn;
    regAddr          regBAddr;

    modport decoder (
        output dirtyTrigger, unitEn, wbSrc, minorOp, immEn, upperImmEn, immediate,
               regAReadEn, regAWriteEn, regAAddr, regBReadEn, regBAddr
    );

    // Only what the hazard check needs
    modport scoreboard (
        input dirtyTrigger, regAReadEn, regAWriteEn, regAAddr, regBReadEn, regBAddr
    );

    modport issue (
        input dirtyTrigger, unitEn, wbSrc, minorOp, immEn, upperImmEn, immediate,
              regAReadEn, regAWriteEn, regAAddr, regBReadEn, regBAddr
    );

endinterface

`default_nettype wire

// File: logic/CorePkg.sv
`default_nettype none

`include "core_consts.svh"

package CorePkg;

    // Data value moved between registers and units
    typedef logic [`DATA_WIDTH-1:0] dataWord;

    // Register file index
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddr;

    // Operation selector inside a functional unit
    typedef logic [`MINOR_OP_MSB-`MINOR_OP_LSB:0] minorOp;

    // One-hot unit select
    // bit 0 simple ALU 0, bit 1 simple ALU 1, bit 2 complex ALU,
    // bit 3 memory, bit 4 branch
    typedef logic [4:0] unitEnable;

    // Writeback source
    // 01 PC plus one, 10 ALU 0 or immediate, 11 ALU 1, 00 reserved
    typedef logic [1:0] wbSource;

endpackage

`default_nettype wire

// File: include/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath and register file sizes
`define DATA_WIDTH      16
`define INSTR_WIDTH     16
`define REG_COUNT       16
`define REG_ADDR_WIDTH  4

// Instruction field positions
`define OPCODE_MSB      15
`define OPCODE_LSB      12
`define IMM_SEL_MSB     13
`define IMM_SEL_LSB     12
`define REG_A_MSB       11
`define REG_A_LSB       8
`define MINOR_OP_MSB    7
`define MINOR_OP_LSB    4
`define REG_B_MSB       3
`define REG_B_LSB       0

// Minor opcode that immediate forms execute with
`define IMM_MINOR_OP    4'h7

`endif
